//--- list.f
source/motor_pkg.sv
source/hall_pkg.sv
source/pwm_timebase.sv
source/command_latch.sv
source/hall_commutator.sv
source/half_bridge.sv
source/bridge_stage.sv
source/motor_drive.sv
testbench/motor_drive_chk.sv
testbench/motor_drive_tb.sv

//--- testbench/motor_drive_tb.sv
// Testbench for the BLDC drive that replays a table of Hall and command rows against a model
`timescale 1ns/1ps

module motor_drive_tb
	import motor_pkg::*;
	import hall_pkg::*;
;

	// One step of the table, mid_level is written halfway through the checked period
	typedef struct packed {
		logic [hall_width-1:0] hall;
		logic                  dir;
		logic [pwm_width-1:0]  level;
		logic [1:0]            decay;
		logic                  fault;
		logic [pwm_width-1:0]  mid_level;
	} row_t;

	logic                  clk;
	logic                  rst_n;
	logic                  new_direction;
	logic [pwm_width-1:0]  new_level;
	decay_mode_t           new_decay;
	logic [hall_width-1:0] hall;
	logic [motor_bits-1:0] motor_out;
	logic                  fault;
	logic [pwm_width-1:0]  pwm_phase;

	row_t rows[$];
	logic [15:0] lfsr = 16'd21;
	int cycles = 0;
	int cycle_limit = 1100;

	// Reference state, advanced once per clock from the rules of the drive
	logic [pwm_width-1:0]  ref_phase = '0;
	logic [motor_bits-1:0] ref_out = '0;
	logic                  m_dir = 1'b0;
	logic [pwm_width-1:0]  m_level = '0;
	logic [1:0]            m_decay = decay_slow;
	logic [hall_width-1:0] m_meta = '0;
	logic [hall_width-1:0] m_sync = '0;

	motor_drive motor_drive_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Galois LFSR with a 16-bit polynomial, the new low bit is the bit taken
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	task automatic take_bits(input int count, output logic [pwm_width-1:0] value);
		value = '0;
		for (int b = 0; b < count; b++) begin
			lfsr  = lfsr_step(lfsr);
			value = {value[pwm_width-2:0], lfsr[0]};
		end
	endtask

	task automatic add_row(input logic [2:0] h, input logic d, input logic [8:0] l,
			input logic [1:0] m, input logic f, input logic [8:0] mid);
		rows.push_back({h, d, l, m, f, mid});
	endtask

	// Forward six-step table, reverse rotation is the bitwise complement
	function automatic logic [motor_bits-1:0] commutate(input logic [2:0] code, input logic dir);
		logic [motor_bits-1:0] pattern;
		case (hall_code_t'(code))
			sector_101: pattern = {bridge_high, bridge_low, bridge_off};
			sector_100: pattern = {bridge_high, bridge_off, bridge_low};
			sector_110: pattern = {bridge_off, bridge_high, bridge_low};
			sector_010: pattern = {bridge_low, bridge_high, bridge_off};
			sector_011: pattern = {bridge_low, bridge_off, bridge_high};
			sector_001: pattern = {bridge_off, bridge_low, bridge_high};
			default:    pattern = '0;
		endcase
		return dir ? ~pattern : pattern;
	endfunction

	// Gate code of one phase for a given PWM phase, level and decay mode
	function automatic logic [1:0] phase_code(input logic [1:0] code, input int phase,
			input int level, input logic [1:0] decay);
		logic [1:0] c;
		logic       driven;
		c      = (code == bridge_noff) ? bridge_off : code;
		driven = (c != bridge_off);
		if (decay == decay_fast_drive)
			return (phase < level) ? c : bridge_off;
		if (decay == decay_fast_brake)
			return (phase < level && driven) ? bridge_low : bridge_off;
		if (phase < level)
			return c;
		// Slow decay only brakes once the dead time past the level has gone by
		return (phase >= level + int'(dead_time) && driven) ? bridge_low : bridge_off;
	endfunction

	function automatic logic [motor_bits-1:0] drive_pattern(input logic [8:0] phase,
			input logic [8:0] level, input logic [1:0] decay, input logic [5:0] pattern);
		logic [motor_bits-1:0] result;
		for (int p = 0; p < 3; p++)
			result[2*p +: 2] = phase_code(pattern[2*p +: 2], phase, level, decay);
		return result;
	endfunction

	task automatic expect_equal(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (expected === actual) else begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// Steps the model across one rising edge, then compares it with the DUT
	// Inputs were driven 5 ns after the previous edge, so they are what the edge samples
	task automatic step_cycle();
		ref_out = drive_pattern(ref_phase, m_level, m_decay, commutate(m_sync, m_dir));
		if (ref_phase == update_phase) begin
			m_dir   = new_direction;
			m_level = new_level;
			m_decay = new_decay;
		end
		m_sync    = m_meta;
		m_meta    = hall;
		ref_phase = ref_phase + 1'b1;
		@(posedge clk);
		#5;
		expect_equal("pwm_phase", ref_phase, pwm_phase);
		expect_equal("motor_out", ref_out, motor_out);
		expect_equal("fault", (m_sync == hall_all_low || m_sync == hall_all_high), fault);
	endtask

	initial begin
		row_t row;
		logic [pwm_width-1:0] h, d, l, m;
		rst_n         = 1'b0;
		hall          = '0;
		new_direction = 1'b0;
		new_level     = '0;
		new_decay     = decay_slow;
		// Every valid sector in both directions at full duty
		for (int s = 1; s < 7; s++)
			for (int dir = 0; dir < 2; dir++)
				add_row(s[2:0], dir[0], 9'd511, decay_fast_drive, 1'b0, 9'd511);
		add_row(3'b000, 1'b0, 9'd511, decay_fast_drive, 1'b1, 9'd511);
		add_row(3'b111, 1'b1, 9'd511, decay_fast_drive, 1'b1, 9'd511);
		add_row(3'b101, 1'b0, 9'd200, decay_fast_drive, 1'b0, 9'd200);
		add_row(3'b011, 1'b1, 9'd0, decay_fast_drive, 1'b0, 9'd0);
		add_row(3'b100, 1'b0, 9'd300, decay_slow, 1'b0, 9'd300);
		// Level plus dead time runs past the top of the period here
		add_row(3'b011, 1'b1, 9'd505, decay_slow, 1'b0, 9'd505);
		add_row(3'b110, 1'b0, 9'd0, decay_slow, 1'b0, 9'd0);
		add_row(3'b110, 1'b0, 9'd150, decay_fast_brake, 1'b0, 9'd150);
		add_row(3'b001, 1'b1, 9'd400, decay_fast_brake, 1'b0, 9'd400);
		// Level rewritten mid-period must wait for the period boundary
		add_row(3'b010, 1'b0, 9'd300, decay_fast_drive, 1'b0, 9'd0);
		add_row(3'b010, 1'b1, 9'd100, decay_slow, 1'b0, 9'd450);
		for (int r = 0; r < 8; r++) begin
			take_bits(3, h);
			take_bits(1, d);
			take_bits(9, l);
			take_bits(2, m);
			add_row(h[2:0], d[0], l, (m[1:0] == 2'b11) ? decay_slow : m[1:0],
				(h[2:0] == 3'b000 || h[2:0] == 3'b111), l);
		end
		// A row needs at most two periods plus a few cycles
		cycle_limit = (rows.size() + 2) * 1100;
		repeat (10) @(posedge clk);
		#5;
		rst_n = 1'b1;
		foreach (rows[r]) begin
			row           = rows[r];
			hall          = row.hall;
			new_direction = row.dir;
			new_level     = row.level;
			new_decay     = decay_mode_t'(row.decay);
			while (ref_phase != update_phase)
				step_cycle();
			step_cycle();
			// Let the Hall value through the synchronizer and the output register
			repeat (3) step_cycle();
			for (int k = 0; k < 512; k++) begin
				if (ref_phase == 9'd256)
					new_level = row.mid_level;
				step_cycle();
				expect_equal("fault", row.fault, fault);
			end
		end
		$display("TEST PASSED");
		$finish;
	end

	initial begin
		while (cycles <= cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout reached after %0d cycles before the table was finished", cycles);
		$display("TEST FAILED");
		$fatal(1);
	end

endmodule

//--- testbench/motor_drive_chk.sv
// Checker bound to the BLDC drive top level that watches the phase counter and gate outputs
`timescale 1ns/1ps

module motor_drive_chk
	import motor_pkg::*;
(
	input logic                  clk,
	input logic                  rst_n,
	input logic [pwm_width-1:0]  pwm_phase,
	input logic [motor_bits-1:0] motor_out,
	input logic                  fault
);

	// The counter steps by one and wraps from 511 to 0
	phase_step: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> pwm_phase == 9'($past(pwm_phase) + 1'b1))
		else $error("pwm_phase did not advance by one");

	// Both switches of one half bridge on at once would short the supply
	no_shoot_through: assert property (@(posedge clk) disable iff (!rst_n)
		motor_out[1:0] != 2'b11 && motor_out[3:2] != 2'b11 && motor_out[5:4] != 2'b11)
		else $error("motor_out has a half bridge with both switches on");

	// A Hall fault must open every bridge on the next cycle
	fault_off: assert property (@(posedge clk) disable iff (!rst_n)
		fault |=> motor_out == '0)
		else $error("motor_out not all off after a Hall fault");

endmodule

bind motor_drive motor_drive_chk motor_drive_chk_i (.*);

//--- source/motor_drive.sv
// Top level of the Hall-sensored BLDC drive with PWM timebase, command latch and bridges
`timescale 1ns/1ps

module motor_drive
	import motor_pkg::*;
	import hall_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  new_direction,
	input  logic [pwm_width-1:0]  new_level,
	input  decay_mode_t           new_decay,
	input  logic [hall_width-1:0] hall,
	output logic [motor_bits-1:0] motor_out,
	output logic                  fault,
	output logic [pwm_width-1:0]  pwm_phase
);

	logic                  update_strobe;
	logic                  direction;
	logic [pwm_width-1:0]  pwm_level;
	decay_mode_t           decay_mode;
	logic [motor_bits-1:0] bridge_drive;

	pwm_timebase pwm_timebase_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.pwm_phase     (pwm_phase),
		.update_strobe (update_strobe)
	);

	command_latch command_latch_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.update_strobe (update_strobe),
		.new_direction (new_direction),
		.new_level     (new_level),
		.new_decay     (new_decay),
		.direction     (direction),
		.pwm_level     (pwm_level),
		.decay_mode    (decay_mode)
	);

	// Hall input is asynchronous, the commutator brings it into the clock domain
	hall_commutator hall_commutator_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.hall         (hall),
		.direction    (direction),
		.bridge_drive (bridge_drive),
		.fault        (fault)
	);

	bridge_stage bridge_stage_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.pwm_phase    (pwm_phase),
		.pwm_level    (pwm_level),
		.decay_mode   (decay_mode),
		.bridge_drive (bridge_drive),
		.motor_out    (motor_out)
	);

endmodule

//--- source/bridge_stage.sv
// Bridge stage that compares the PWM phase with dead time and registers the gate outputs
`timescale 1ns/1ps

module bridge_stage
	import motor_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [pwm_width-1:0]  pwm_phase,
	input  logic [pwm_width-1:0]  pwm_level,
	input  decay_mode_t           decay_mode,
	input  logic [motor_bits-1:0] bridge_drive,
	output logic [motor_bits-1:0] motor_out
);

	logic                  pwm_active;
	logic                  pwm_inverted;
	logic [pwm_width:0]    inverted_threshold;
	logic [motor_bits-1:0] bridge_next;

	// Dead time only delays the inverted side, so the fast decay modes are not affected
	// The extra top bit keeps level plus dead time from wrapping to a small value
	assign inverted_threshold = {1'b0, pwm_level} + dead_time;
	assign pwm_active         = (pwm_phase < pwm_level);
	assign pwm_inverted       = ({1'b0, pwm_phase} >= inverted_threshold);

	// One decoder per motor phase on its two-bit slice
	for (genvar i = 0; i < motor_bits / 2; i++) begin : gen_phase
		half_bridge half_bridge_i (
			.pwm_active   (pwm_active),
			.pwm_inverted (pwm_inverted),
			.decay_mode   (decay_mode),
			.bridge_in    (bridge_code_t'(bridge_drive[2*i+1:2*i])),
			.bridge_out   (bridge_next[2*i+1:2*i])
		);
	end

	// Registering removes the decode glitches before they reach the gate drivers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			motor_out <= '0;
		end else begin
			motor_out <= bridge_next;
		end
	end

endmodule

//--- source/half_bridge.sv
// Half bridge decoder that picks one phase's gate code from the PWM state and decay mode
`timescale 1ns/1ps

module half_bridge
	import motor_pkg::*;
(
	input  logic         pwm_active,
	input  logic         pwm_inverted,
	input  decay_mode_t  decay_mode,
	input  bridge_code_t bridge_in,
	output bridge_code_t bridge_out
);

	// Input with bridge_noff folded back to plain off
	bridge_code_t clean_in;

	// Set when the commutator drives this phase either way
	logic driven;

	assign clean_in = (bridge_in == bridge_noff) ? bridge_off : bridge_in;
	assign driven   = (clean_in == bridge_low) || (clean_in == bridge_high);

	always_comb begin
		case (decay_mode)
			decay_slow: begin
				// Off-time current recirculates through the low sides
				// The dead time gap between the two parts keeps both switches from conducting
				if (pwm_active) begin
					bridge_out = clean_in;
				end else if (pwm_inverted && driven) begin
					bridge_out = bridge_low;
				end else begin
					bridge_out = bridge_off;
				end
			end
			// Off-time current returns through the body diodes into the supply
			decay_fast_drive: bridge_out = pwm_active ? clean_in : bridge_off;
			decay_fast_brake: begin
				// Shorting the driven windings to ground brakes the motor
				// A floating phase stays open so it does not load the back EMF
				bridge_out = (pwm_active && driven) ? bridge_low : bridge_off;
			end
			default: bridge_out = bridge_off;
		endcase
	end

endmodule

//--- source/hall_commutator.sv
// Hall commutator that synchronizes the sensors and produces the six-step bridge pattern
`timescale 1ns/1ps

module hall_commutator
	import motor_pkg::*;
	import hall_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [hall_width-1:0] hall,
	input  logic                  direction,
	output logic [motor_bits-1:0] bridge_drive,
	output logic                  fault
);

	// First stage may go metastable, the second one feeds the decode
	logic [hall_width-1:0] hall_meta;
	hall_code_t            hall_sync;

	// Pattern for forward rotation before the direction is applied
	logic [motor_bits-1:0] com_pattern;

	// Both stages start at all low, so fault stays up until real Hall values arrive
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hall_meta <= '0;
			hall_sync <= hall_all_low;
		end else begin
			hall_meta <= hall;
			hall_sync <= hall_code_t'(hall_meta);
		end
	end

	// Six-step table, phase A in the top two bits and phase C in the bottom two
	// In each sector one phase is pulled high, one pulled low and one left floating
	always_comb begin
		fault = 1'b0;
		case (hall_sync)
			sector_101: com_pattern = {bridge_high, bridge_low, bridge_off};
			sector_100: com_pattern = {bridge_high, bridge_off, bridge_low};
			sector_110: com_pattern = {bridge_off, bridge_high, bridge_low};
			sector_010: com_pattern = {bridge_low, bridge_high, bridge_off};
			sector_011: com_pattern = {bridge_low, bridge_off, bridge_high};
			sector_001: com_pattern = {bridge_off, bridge_low, bridge_high};
			default: begin
				// All low or all high means a sensor or its supply is broken
				com_pattern = {bridge_off, bridge_off, bridge_off};
				fault       = 1'b1;
			end
		endcase
	end

	// Reverse rotation swaps high and low in every phase
	// Complementing does exactly that, an off phase turns into bridge_noff
	// The half bridges treat bridge_noff as off
	assign bridge_drive = direction ? ~com_pattern : com_pattern;

endmodule

//--- source/command_latch.sv
// Command latch that takes direction, duty level and decay mode once per PWM period
`timescale 1ns/1ps

module command_latch
	import motor_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 update_strobe,
	input  logic                 new_direction,
	input  logic [pwm_width-1:0] new_level,
	input  decay_mode_t          new_decay,
	output logic                 direction,
	output logic [pwm_width-1:0] pwm_level,
	output decay_mode_t          decay_mode
);

	// The CPU may change the new_* levels at any time
	// Loading them only at the strobe keeps a period from being cut short
	// A change in the middle of a period would leave a runt pulse on the bridge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			direction  <= 1'b0;
			pwm_level  <= '0;
			decay_mode <= decay_slow;
		end else if (update_strobe) begin
			direction  <= new_direction;
			pwm_level  <= new_level;
			decay_mode <= new_decay;
		end
	end

	// With the strobe at phase 510 the new values are in place for phase 511
	// That phase sits above every level below 511, so nothing visible switches mid-period

endmodule

//--- source/pwm_timebase.sv
// PWM timebase that counts the phase and flags the command update phase
`timescale 1ns/1ps

module pwm_timebase
	import motor_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	output logic [pwm_width-1:0] pwm_phase,
	output logic                 update_strobe
);

	// Free-running counter, the natural binary wrap gives the 512 cycle period
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pwm_phase <= '0;
		end else begin
			pwm_phase <= pwm_phase + 1'b1;
		end
	end

	// The period boundary is decoded only here
	// Downstream blocks use this strobe instead of comparing the phase themselves
	assign update_strobe = (pwm_phase == update_phase);

endmodule

//--- source/hall_pkg.sv
// Hall sensor package with the sensor code width and the sector encoding
package hall_pkg;

	// One bit per Hall sensor, three sensors spaced 120 electrical degrees apart
	localparam int hall_width = 3;

	// Each valid code names the sector it stands for
	// All low and all high cannot occur on a healthy motor and are treated as faults
	typedef enum logic [hall_width-1:0] {
		hall_all_low  = 3'b000,
		sector_001    = 3'b001,
		sector_010    = 3'b010,
		sector_011    = 3'b011,
		sector_100    = 3'b100,
		sector_101    = 3'b101,
		sector_110    = 3'b110,
		hall_all_high = 3'b111
	} hall_code_t;

	// A broken single sensor wire can still yield a valid looking code
	// That case shows up as a stalled motor and is left to the CPU

endpackage

//--- source/motor_pkg.sv
// Motor drive package with bridge output codes, decay modes and PWM timing constants
package motor_pkg;

	// The PWM phase counter is this wide and wraps at its full range
	localparam int pwm_width = 9;

	// Three motor phases with a two-bit bridge code each
	localparam int motor_bits = 6;

	// Commands are taken at this phase so they apply from the last phase of the period on
	localparam logic [pwm_width-1:0] update_phase = 'd510;

	// Gap in clock cycles between the active side turning off and the inverted side turning on
	// Carries one extra bit so that level plus dead time cannot overflow
	localparam logic [pwm_width:0] dead_time = 'd10;

	// Gate drive code for one half bridge, high side in the upper bit
	// bridge_noff is the complement of bridge_off and shows up after a direction reversal
	typedef enum logic [1:0] {
		bridge_off  = 2'b00,
		bridge_low  = 2'b01,
		bridge_high = 2'b10,
		bridge_noff = 2'b11
	} bridge_code_t;

	// How the bridge behaves outside the active part of the PWM period
	typedef enum logic [1:0] {
		decay_slow       = 2'b00,
		decay_fast_drive = 2'b01,
		decay_fast_brake = 2'b10
	} decay_mode_t;

endpackage
